// File: rtl/fcpu_pkg.sv
package fcpu_pkg;

   localparam int DATA_W     = 32;
   localparam int INSTR_W    = 32;
   localparam int REG_ADDR_W = 5; // r0 reads zero
   localparam int OPC_W      = 6;

   // R-format ops
   localparam logic [OPC_W-1:0] OP_ADD  = 6'h01;
   localparam logic [OPC_W-1:0] OP_SUB  = 6'h02;
   localparam logic [OPC_W-1:0] OP_AND  = 6'h03;
   localparam logic [OPC_W-1:0] OP_OR   = 6'h04;
   localparam logic [OPC_W-1:0] OP_XOR  = 6'h05;
   // I-format ops
   localparam logic [OPC_W-1:0] OP_ADDI = 6'h08;
   localparam logic [OPC_W-1:0] OP_XORI = 6'h09;

   typedef struct packed {
      logic [OPC_W-1:0]      opcode;
      logic [REG_ADDR_W-1:0] rd;
      logic [REG_ADDR_W-1:0] rs1;
      logic [REG_ADDR_W-1:0] rs2;
      logic [10:0]           pad;
   } r_fmt_t;

   typedef struct packed {
      logic [OPC_W-1:0]      opcode;
      logic [REG_ADDR_W-1:0] rd;
      logic [REG_ADDR_W-1:0] rs1;
      logic signed [15:0]    imm;
   } i_fmt_t;

   // opcode picks the view
   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
   } instr_u;

endpackage

// File: rtl/reorder_buffer.sv
`timescale 1ns/1ns

module reorder_buffer #(
   parameter int ROB_ID_W = 3
) (
   input  logic                            clk,
   input  logic                            nrst,
   // reserve
   input  logic                            i_rsv_valid,
   output logic                            o_rsv_ready,
   output logic [ROB_ID_W-1:0]             o_rsv_id,
   input  logic [fcpu_pkg::REG_ADDR_W-1:0] i_dst_reg,
   input  logic [fcpu_pkg::OPC_W-1:0]      i_opcode,
   // operand read
   input  logic [ROB_ID_W-1:0]             i_rd_id0,
   input  logic [ROB_ID_W-1:0]             i_rd_id1,
   output logic                            o_rd_ready0,
   output logic                            o_rd_ready1,
   output logic [fcpu_pkg::DATA_W-1:0]     o_rd_data0,
   output logic [fcpu_pkg::DATA_W-1:0]     o_rd_data1,
   // cdb
   input  logic                            i_cdb_valid,
   input  logic [ROB_ID_W-1:0]             i_cdb_id,
   input  logic [fcpu_pkg::DATA_W-1:0]     i_cdb_data,
   // commit
   output logic                            o_commit_valid,
   output logic [ROB_ID_W-1:0]             o_commit_id,
   output logic [fcpu_pkg::REG_ADDR_W-1:0] o_commit_reg,
   output logic [fcpu_pkg::DATA_W-1:0]     o_commit_data,
   input  logic                            i_commit_ready
);
   import fcpu_pkg::*;

   localparam int DEPTH = 2**ROB_ID_W;

   typedef struct packed {
      logic                  valid;
      logic                  ready; // result captured
      logic [REG_ADDR_W-1:0] dst_reg;
      logic [OPC_W-1:0]      opcode;
      logic [DATA_W-1:0]     content;
   } station_t;

   station_t            station [DEPTH];
   station_t            head_station;
   logic [ROB_ID_W-1:0] head;
   logic [ROB_ID_W-1:0] tail;
   logic                rsv_fire;
   logic                rel_fire;

   assign head_station = station[head];

   // full when the head slot is taken and tail caught up
   assign o_rsv_ready = !(head_station.valid && head == tail);
   assign o_rsv_id    = tail;
   assign rsv_fire    = i_rsv_valid && o_rsv_ready;

   assign o_commit_valid = head_station.valid && head_station.ready;
   assign o_commit_id    = head;
   assign o_commit_reg   = head_station.dst_reg;
   assign o_commit_data  = head_station.content;
   assign rel_fire       = o_commit_valid && i_commit_ready;

   // finished but not yet committed results
   assign o_rd_ready0 = station[i_rd_id0].ready;
   assign o_rd_data0  = station[i_rd_id0].content;
   assign o_rd_ready1 = station[i_rd_id1].ready;
   assign o_rd_data1  = station[i_rd_id1].content;

   always_ff @(posedge clk) begin
      if (nrst) begin
         head <= '0;
         tail <= '0;
         for (int k = 0; k < DEPTH; k++) begin
            station[k] <= '0;
         end
      end else begin
         if (rsv_fire) begin
            tail <= tail + 1'b1; // wraps at depth
         end
         if (rel_fire) begin
            head <= head + 1'b1;
         end
         for (int k = 0; k < DEPTH; k++) begin
            if (rel_fire && head == k) begin
               station[k] <= '0;
            end else if (rsv_fire && tail == k) begin
               station[k] <= '{valid: 1'b1, ready: 1'b0, dst_reg: i_dst_reg,
                               opcode: i_opcode, content: '0};
            end else if (i_cdb_valid && i_cdb_id == k && station[k].valid) begin
               station[k].ready   <= 1'b1;
               station[k].content <= i_cdb_data;
            end
         end
      end
   end

endmodule

// File: rtl/dispatch_unit.sv
`timescale 1ns/1ns

module dispatch_unit #(
   parameter int ROB_ID_W = 3
) (
   input  logic                            i_instr_valid,
   input  logic [fcpu_pkg::INSTR_W-1:0]    i_instr,
   output logic                            o_instr_ready,
   // rob reserve
   output logic                            o_rsv_valid,
   input  logic                            i_rsv_ready,
   input  logic [ROB_ID_W-1:0]             i_rsv_id,
   output logic [fcpu_pkg::REG_ADDR_W-1:0] o_dst_reg,
   output logic [fcpu_pkg::OPC_W-1:0]      o_opcode,
   // rob operand read
   output logic [ROB_ID_W-1:0]             o_rd_id0,
   output logic [ROB_ID_W-1:0]             o_rd_id1,
   input  logic                            i_rd_ready0,
   input  logic                            i_rd_ready1,
   input  logic [fcpu_pkg::DATA_W-1:0]     i_rd_data0,
   input  logic [fcpu_pkg::DATA_W-1:0]     i_rd_data1,
   // register lookup
   output logic [fcpu_pkg::REG_ADDR_W-1:0] o_src0,
   output logic [fcpu_pkg::REG_ADDR_W-1:0] o_src1,
   input  logic [fcpu_pkg::DATA_W-1:0]     i_src_val0,
   input  logic [fcpu_pkg::DATA_W-1:0]     i_src_val1,
   input  logic                            i_src_busy0,
   input  logic                            i_src_busy1,
   input  logic [ROB_ID_W-1:0]             i_src_tag0,
   input  logic [ROB_ID_W-1:0]             i_src_tag1,
   // busy tagging
   output logic                            o_set_busy,
   output logic [fcpu_pkg::REG_ADDR_W-1:0] o_set_reg,
   output logic [ROB_ID_W-1:0]             o_set_tag,
   // station write
   output logic                            o_rs_write,
   output logic [ROB_ID_W-1:0]             o_rs_id,
   output logic [fcpu_pkg::OPC_W-1:0]      o_rs_opcode,
   output logic [fcpu_pkg::DATA_W-1:0]     o_rs_val0,
   output logic [fcpu_pkg::DATA_W-1:0]     o_rs_val1,
   output logic [ROB_ID_W-1:0]             o_rs_tag0,
   output logic [ROB_ID_W-1:0]             o_rs_tag1,
   output logic                            o_rs_vld0,
   output logic                            o_rs_vld1,
   input  logic                            i_rs_full,
   // cdb
   input  logic                            i_cdb_valid,
   input  logic [ROB_ID_W-1:0]             i_cdb_id,
   input  logic [fcpu_pkg::DATA_W-1:0]     i_cdb_data
);
   import fcpu_pkg::*;

   instr_u                ins;
   logic                  is_imm;
   logic                  fire;
   logic [REG_ADDR_W-1:0] rd;
   logic [DATA_W-1:0]     imm_ext;
   logic [DATA_W:0]       opnd0; // {valid, value}
   logic [DATA_W:0]       opnd1;

   // register file, finished rob entry, cdb this cycle, else wait on tag
   function automatic logic [DATA_W:0] resolve(input logic [DATA_W-1:0] val,
                                               input logic busy,
                                               input logic [ROB_ID_W-1:0] tag,
                                               input logic rob_rdy,
                                               input logic [DATA_W-1:0] rob_data);
      if (!busy) return {1'b1, val};
      if (rob_rdy) return {1'b1, rob_data};
      if (i_cdb_valid && i_cdb_id == tag) return {1'b1, i_cdb_data};
      return '0;
   endfunction

   assign ins    = i_instr;
   assign is_imm = (ins.r.opcode == OP_ADDI) || (ins.r.opcode == OP_XORI);

   // rd and rs1 sit at the same bits in both views
   assign rd      = ins.r.rd;
   assign o_src0  = ins.r.rs1;
   assign o_src1  = is_imm ? '0 : ins.r.rs2;
   assign imm_ext = {{(DATA_W-16){ins.i.imm[15]}}, ins.i.imm};

   // only place where both rob and station room are checked
   assign o_instr_ready = i_rsv_ready && !i_rs_full;
   assign fire          = i_instr_valid && o_instr_ready;

   assign o_rsv_valid = i_instr_valid && !i_rs_full;
   assign o_dst_reg   = rd;
   assign o_opcode    = ins.r.opcode;

   assign o_rd_id0 = i_src_tag0;
   assign o_rd_id1 = i_src_tag1;

   assign o_set_busy = fire && (rd != '0); // r0 never goes busy
   assign o_set_reg  = rd;
   assign o_set_tag  = i_rsv_id;

   assign opnd0 = resolve(i_src_val0, i_src_busy0, i_src_tag0, i_rd_ready0, i_rd_data0);
   assign opnd1 = is_imm ? {1'b1, imm_ext} :
                  resolve(i_src_val1, i_src_busy1, i_src_tag1, i_rd_ready1, i_rd_data1);

   assign o_rs_write  = fire;
   assign o_rs_id     = i_rsv_id;
   assign o_rs_opcode = ins.r.opcode;
   assign o_rs_vld0   = opnd0[DATA_W];
   assign o_rs_val0   = opnd0[DATA_W-1:0];
   assign o_rs_tag0   = i_src_tag0;
   assign o_rs_vld1   = opnd1[DATA_W];
   assign o_rs_val1   = opnd1[DATA_W-1:0];
   assign o_rs_tag1   = i_src_tag1;

endmodule

// File: rtl/alu_station.sv
`timescale 1ns/1ns

module alu_station #(
   parameter int ROB_ID_W = 3,
   parameter int RS_DEPTH = 4
) (
   input  logic                        clk,
   input  logic                        nrst,
   input  logic                        i_rs_write,
   input  logic [ROB_ID_W-1:0]         i_rs_id,
   input  logic [fcpu_pkg::OPC_W-1:0]  i_rs_opcode,
   input  logic [fcpu_pkg::DATA_W-1:0] i_rs_val0,
   input  logic [fcpu_pkg::DATA_W-1:0] i_rs_val1,
   input  logic [ROB_ID_W-1:0]         i_rs_tag0,
   input  logic [ROB_ID_W-1:0]         i_rs_tag1,
   input  logic                        i_rs_vld0,
   input  logic                        i_rs_vld1,
   output logic                        o_rs_full,
   output logic                        o_cdb_valid,
   output logic [ROB_ID_W-1:0]         o_cdb_id,
   output logic [fcpu_pkg::DATA_W-1:0] o_cdb_data
);
   import fcpu_pkg::*;

   localparam int IDX_W = $clog2(RS_DEPTH); // depth of 2 or more

   logic [RS_DEPTH-1:0] busy;
   logic [RS_DEPTH-1:0] vld0;
   logic [RS_DEPTH-1:0] vld1;
   logic [OPC_W-1:0]    op     [RS_DEPTH];
   logic [ROB_ID_W-1:0] rob_id [RS_DEPTH];
   logic [ROB_ID_W-1:0] tag0   [RS_DEPTH];
   logic [ROB_ID_W-1:0] tag1   [RS_DEPTH];
   logic [DATA_W-1:0]   val0   [RS_DEPTH];
   logic [DATA_W-1:0]   val1   [RS_DEPTH];
   logic [IDX_W-1:0]    age    [RS_DEPTH]; // number of younger slots
   logic [IDX_W-1:0]    free_sel;
   logic [IDX_W-1:0]    iss_sel;
   logic                iss_ok;

   function automatic logic [DATA_W-1:0] alu(input logic [OPC_W-1:0] opc,
                                             input logic [DATA_W-1:0] a,
                                             input logic [DATA_W-1:0] b);
      case (opc)
         OP_ADD, OP_ADDI: return a + b;
         OP_SUB:          return a - b;
         OP_AND:          return a & b;
         OP_OR:           return a | b;
         OP_XOR, OP_XORI: return a ^ b;
         default:         return '0;
      endcase
   endfunction

   assign o_rs_full = &busy;

   always_comb begin
      free_sel = '0;
      for (int k = RS_DEPTH-1; k >= 0; k--) begin
         if (!busy[k]) free_sel = IDX_W'(k); // lowest free wins
      end
   end

   // oldest slot with both operands in hand
   always_comb begin
      iss_ok  = 1'b0;
      iss_sel = '0;
      for (int k = 0; k < RS_DEPTH; k++) begin
         if (busy[k] && vld0[k] && vld1[k] && (!iss_ok || age[k] > age[iss_sel])) begin
            iss_ok  = 1'b1;
            iss_sel = IDX_W'(k);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         busy        <= '0;
         vld0        <= '0;
         vld1        <= '0;
         o_cdb_valid <= 1'b0;
         for (int k = 0; k < RS_DEPTH; k++) begin
            age[k] <= '0;
         end
      end else begin
         o_cdb_valid <= iss_ok;
         for (int k = 0; k < RS_DEPTH; k++) begin
            if (busy[k]) begin
               age[k] <= age[k] + IDX_W'(i_rs_write)
                         - IDX_W'(iss_ok && age[k] > age[iss_sel]);
               if (o_cdb_valid && !vld0[k] && tag0[k] == o_cdb_id) begin
                  vld0[k] <= 1'b1;
                  val0[k] <= o_cdb_data;
               end
               if (o_cdb_valid && !vld1[k] && tag1[k] == o_cdb_id) begin
                  vld1[k] <= 1'b1;
                  val1[k] <= o_cdb_data;
               end
            end
         end
         if (iss_ok) begin
            busy[iss_sel] <= 1'b0; // slot frees at issue
         end
         if (i_rs_write) begin
            busy[free_sel]   <= 1'b1;
            age[free_sel]    <= '0;
            op[free_sel]     <= i_rs_opcode;
            rob_id[free_sel] <= i_rs_id;
            vld0[free_sel]   <= i_rs_vld0;
            val0[free_sel]   <= i_rs_val0;
            tag0[free_sel]   <= i_rs_tag0;
            vld1[free_sel]   <= i_rs_vld1;
            val1[free_sel]   <= i_rs_val1;
            tag1[free_sel]   <= i_rs_tag1;
         end
      end
   end

   // result goes out on the cdb the cycle after issue
   always_ff @(posedge clk) begin
      o_cdb_id   <= rob_id[iss_sel];
      o_cdb_data <= alu(op[iss_sel], val0[iss_sel], val1[iss_sel]);
   end

endmodule

// File: rtl/reg_file.sv
`timescale 1ns/1ns

module reg_file #(
   parameter int ROB_ID_W = 3
) (
   input  logic                            clk,
   input  logic                            nrst,
   // lookup
   input  logic [fcpu_pkg::REG_ADDR_W-1:0] i_rd_addr0,
   input  logic [fcpu_pkg::REG_ADDR_W-1:0] i_rd_addr1,
   output logic [fcpu_pkg::DATA_W-1:0]     o_rd_val0,
   output logic [fcpu_pkg::DATA_W-1:0]     o_rd_val1,
   output logic                            o_rd_busy0,
   output logic                            o_rd_busy1,
   output logic [ROB_ID_W-1:0]             o_rd_tag0,
   output logic [ROB_ID_W-1:0]             o_rd_tag1,
   // rename
   input  logic                            i_set_busy,
   input  logic [fcpu_pkg::REG_ADDR_W-1:0] i_set_reg,
   input  logic [ROB_ID_W-1:0]             i_set_tag,
   // commit
   input  logic                            i_commit_valid,
   input  logic                            i_commit_ready,
   input  logic [ROB_ID_W-1:0]             i_commit_id,
   input  logic [fcpu_pkg::REG_ADDR_W-1:0] i_commit_reg,
   input  logic [fcpu_pkg::DATA_W-1:0]     i_commit_data
);
   import fcpu_pkg::*;

   localparam int NREG = 2**REG_ADDR_W;

   logic [DATA_W-1:0]   regs [NREG];
   logic [ROB_ID_W-1:0] tag  [NREG]; // rob id of the newest writer
   logic [NREG-1:0]     busy;
   logic                commit;

   assign commit = i_commit_valid && i_commit_ready;

   assign o_rd_val0  = regs[i_rd_addr0];
   assign o_rd_busy0 = busy[i_rd_addr0];
   assign o_rd_tag0  = tag[i_rd_addr0];
   assign o_rd_val1  = regs[i_rd_addr1];
   assign o_rd_busy1 = busy[i_rd_addr1];
   assign o_rd_tag1  = tag[i_rd_addr1];

   always_ff @(posedge clk) begin
      if (nrst) begin
         busy <= '0;
         for (int k = 0; k < NREG; k++) begin
            regs[k] <= '0;
         end
      end else begin
         if (commit && i_commit_reg != '0) begin
            regs[i_commit_reg] <= i_commit_data;
            if (tag[i_commit_reg] == i_commit_id) begin
               busy[i_commit_reg] <= 1'b0; // no newer writer pending
            end
         end
         // later assignment, so a new rename beats the clear
         if (i_set_busy && i_set_reg != '0) begin
            busy[i_set_reg] <= 1'b1;
            tag[i_set_reg]  <= i_set_tag;
         end
      end
   end

endmodule

// File: rtl/fcpu_backend.sv
`timescale 1ns/1ns

module fcpu_backend #(
   parameter int ROB_ID_W = 3,
   parameter int RS_DEPTH = 4
) (
   input  logic                            clk,
   input  logic                            nrst,
   input  logic                            i_instr_valid,
   input  logic [fcpu_pkg::INSTR_W-1:0]    i_instr,
   output logic                            o_instr_ready,
   output logic                            o_commit_valid,
   output logic [fcpu_pkg::REG_ADDR_W-1:0] o_commit_reg,
   output logic [fcpu_pkg::DATA_W-1:0]     o_commit_data,
   input  logic                            i_commit_ready
);
   import fcpu_pkg::*;

   logic                  rsv_valid;
   logic                  rsv_ready;
   logic [ROB_ID_W-1:0]   rsv_id;
   logic [REG_ADDR_W-1:0] dst_reg;
   logic [OPC_W-1:0]      opcode;
   logic [ROB_ID_W-1:0]   rd_id0;
   logic [ROB_ID_W-1:0]   rd_id1;
   logic                  rd_ready0;
   logic                  rd_ready1;
   logic [DATA_W-1:0]     rd_data0;
   logic [DATA_W-1:0]     rd_data1;
   logic [REG_ADDR_W-1:0] src0;
   logic [REG_ADDR_W-1:0] src1;
   logic [DATA_W-1:0]     src_val0;
   logic [DATA_W-1:0]     src_val1;
   logic                  src_busy0;
   logic                  src_busy1;
   logic [ROB_ID_W-1:0]   src_tag0;
   logic [ROB_ID_W-1:0]   src_tag1;
   logic                  set_busy;
   logic [REG_ADDR_W-1:0] set_reg;
   logic [ROB_ID_W-1:0]   set_tag;
   logic                  rs_write;
   logic [ROB_ID_W-1:0]   rs_id;
   logic [OPC_W-1:0]      rs_opcode;
   logic [DATA_W-1:0]     rs_val0;
   logic [DATA_W-1:0]     rs_val1;
   logic [ROB_ID_W-1:0]   rs_tag0;
   logic [ROB_ID_W-1:0]   rs_tag1;
   logic                  rs_vld0;
   logic                  rs_vld1;
   logic                  rs_full;
   logic                  cdb_valid;
   logic [ROB_ID_W-1:0]   cdb_id;
   logic [DATA_W-1:0]     cdb_data;
   logic [ROB_ID_W-1:0]   commit_id;

   dispatch_unit #(.ROB_ID_W(ROB_ID_W)) u_dispatch (
      .i_instr_valid(i_instr_valid), .i_instr(i_instr), .o_instr_ready(o_instr_ready),
      .o_rsv_valid(rsv_valid), .i_rsv_ready(rsv_ready), .i_rsv_id(rsv_id),
      .o_dst_reg(dst_reg), .o_opcode(opcode),
      .o_rd_id0(rd_id0), .o_rd_id1(rd_id1), .i_rd_ready0(rd_ready0),
      .i_rd_ready1(rd_ready1), .i_rd_data0(rd_data0), .i_rd_data1(rd_data1),
      .o_src0(src0), .o_src1(src1), .i_src_val0(src_val0), .i_src_val1(src_val1),
      .i_src_busy0(src_busy0), .i_src_busy1(src_busy1),
      .i_src_tag0(src_tag0), .i_src_tag1(src_tag1),
      .o_set_busy(set_busy), .o_set_reg(set_reg), .o_set_tag(set_tag),
      .o_rs_write(rs_write), .o_rs_id(rs_id), .o_rs_opcode(rs_opcode),
      .o_rs_val0(rs_val0), .o_rs_val1(rs_val1), .o_rs_tag0(rs_tag0),
      .o_rs_tag1(rs_tag1), .o_rs_vld0(rs_vld0), .o_rs_vld1(rs_vld1),
      .i_rs_full(rs_full),
      .i_cdb_valid(cdb_valid), .i_cdb_id(cdb_id), .i_cdb_data(cdb_data)
   );

   reorder_buffer #(.ROB_ID_W(ROB_ID_W)) u_rob (
      .clk(clk), .nrst(nrst),
      .i_rsv_valid(rsv_valid), .o_rsv_ready(rsv_ready), .o_rsv_id(rsv_id),
      .i_dst_reg(dst_reg), .i_opcode(opcode),
      .i_rd_id0(rd_id0), .i_rd_id1(rd_id1), .o_rd_ready0(rd_ready0),
      .o_rd_ready1(rd_ready1), .o_rd_data0(rd_data0), .o_rd_data1(rd_data1),
      .i_cdb_valid(cdb_valid), .i_cdb_id(cdb_id), .i_cdb_data(cdb_data),
      .o_commit_valid(o_commit_valid), .o_commit_id(commit_id),
      .o_commit_reg(o_commit_reg), .o_commit_data(o_commit_data),
      .i_commit_ready(i_commit_ready)
   );

   alu_station #(.ROB_ID_W(ROB_ID_W), .RS_DEPTH(RS_DEPTH)) u_alu_rs (
      .clk(clk), .nrst(nrst),
      .i_rs_write(rs_write), .i_rs_id(rs_id), .i_rs_opcode(rs_opcode),
      .i_rs_val0(rs_val0), .i_rs_val1(rs_val1), .i_rs_tag0(rs_tag0),
      .i_rs_tag1(rs_tag1), .i_rs_vld0(rs_vld0), .i_rs_vld1(rs_vld1),
      .o_rs_full(rs_full),
      .o_cdb_valid(cdb_valid), .o_cdb_id(cdb_id), .o_cdb_data(cdb_data)
   );

   reg_file #(.ROB_ID_W(ROB_ID_W)) u_regs (
      .clk(clk), .nrst(nrst),
      .i_rd_addr0(src0), .i_rd_addr1(src1), .o_rd_val0(src_val0), .o_rd_val1(src_val1),
      .o_rd_busy0(src_busy0), .o_rd_busy1(src_busy1),
      .o_rd_tag0(src_tag0), .o_rd_tag1(src_tag1),
      .i_set_busy(set_busy), .i_set_reg(set_reg), .i_set_tag(set_tag),
      .i_commit_valid(o_commit_valid), .i_commit_ready(i_commit_ready),
      .i_commit_id(commit_id), .i_commit_reg(o_commit_reg),
      .i_commit_data(o_commit_data)
   );

endmodule

// File: sim/tb_fcpu_backend.sv
`timescale 1ns/1ns

module tb_fcpu_backend;
   import fcpu_pkg::*;

   localparam int ROB_ID_W    = 3;
   localparam int ROB_DEPTH   = 2**ROB_ID_W;
   localparam int NPAT        = 33;
   localparam int SEND_LIMIT  = 100;
   localparam int FILL_LIMIT  = 40; // long enough for the station to drain
   localparam int DRAIN_LIMIT = 100;

   logic                  clk;
   logic                  nrst;
   logic                  i_instr_valid;
   logic [INSTR_W-1:0]    i_instr;
   logic                  o_instr_ready;
   logic                  o_commit_valid;
   logic [REG_ADDR_W-1:0] o_commit_reg;
   logic [DATA_W-1:0]     o_commit_data;
   logic                  i_commit_ready;

   logic [31:0] pat [0:3*NPAT-1]; // word, dest, value per line
   int          exp_q [$];        // accepted lines waiting for commit
   int          mon_idx;
   int          errors;
   int          checks;
   int          tests_run;
   int          tests_failed;
   bit          timed_out;
   bit          rand_ready;
   logic [31:0] rng_ready;
   logic [31:0] rng_gap;

   fcpu_backend #(.ROB_ID_W(ROB_ID_W), .RS_DEPTH(4)) i_fcpu_backend (
      .clk(clk), .nrst(nrst),
      .i_instr_valid(i_instr_valid), .i_instr(i_instr), .o_instr_ready(o_instr_ready),
      .o_commit_valid(o_commit_valid), .o_commit_reg(o_commit_reg),
      .o_commit_data(o_commit_data), .i_commit_ready(i_commit_ready)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   always @(posedge clk) begin
      if (rand_ready) begin
         rng_ready = xorshift(rng_ready);
         i_commit_ready <= rng_ready[7];
      end
   end

   // every commit must match the oldest accepted line
   always @(posedge clk) begin
      if (!nrst && o_commit_valid && i_commit_ready) begin
         checks++;
         if (exp_q.size() == 0) begin
            errors++;
            $display("Error at %0t: commit to r%0d with nothing outstanding", $time,
                     o_commit_reg);
         end else begin
            mon_idx = exp_q.pop_front();
            if (o_commit_reg !== pat[3*mon_idx+1][REG_ADDR_W-1:0] ||
                o_commit_data !== pat[3*mon_idx+2]) begin
               errors++;
               $display("Error at %0t: line %0d committed r%0d = %h, expected r%0d = %h",
                        $time, mon_idx, o_commit_reg, o_commit_data,
                        pat[3*mon_idx+1][REG_ADDR_W-1:0], pat[3*mon_idx+2]);
            end
         end
      end
   end

   // holds one line on the port until it is taken or the limit runs out
   task automatic send_line(input int idx, input int limit, output bit taken);
      int c;
      taken = 1'b0;
      i_instr_valid <= 1'b1;
      i_instr       <= pat[3*idx];
      for (c = 0; c < limit; c++) begin
         @(posedge clk);
         if (o_instr_ready) begin
            taken = 1'b1;
            exp_q.push_back(idx);
            break;
         end
      end
   endtask

   task automatic run_lines(input int first, input int last, input bit gaps);
      bit taken;
      int gap;
      int idx;
      idx = first;
      while (idx <= last && !timed_out) begin
         if (gaps) begin
            rng_gap = xorshift(rng_gap);
            gap = int'(rng_gap % 3);
            if (gap > 0) begin
               i_instr_valid <= 1'b0;
               repeat (gap) @(posedge clk);
            end
         end
         send_line(idx, SEND_LIMIT, taken);
         if (!taken) begin
            $display("line %0d was not accepted within %0d cycles", idx, SEND_LIMIT);
            timed_out = 1'b1;
         end
         idx++;
      end
      i_instr_valid <= 1'b0;
   endtask

   // waits for the outstanding lines to commit, limit restarts on progress
   task automatic drain;
      int c;
      int left;
      c = 0;
      @(negedge clk);
      left = exp_q.size();
      while (exp_q.size() != 0 && c < DRAIN_LIMIT) begin
         @(negedge clk);
         c++;
         if (exp_q.size() < left) begin
            left = exp_q.size();
            c = 0;
         end
      end
      if (exp_q.size() != 0) begin
         $display("no commit arrived for line %0d within %0d cycles", exp_q[0],
                  DRAIN_LIMIT);
         timed_out = 1'b1;
      end
      @(posedge clk);
   endtask

   task automatic report_test(input int num, input string name, input int err_start);
      tests_run++;
      if (errors != err_start || timed_out) begin
         tests_failed++;
         $display("test %0d (%s): failed", num, name);
      end else begin
         $display("test %0d (%s): passed", num, name);
      end
   endtask

   initial begin
      int  err_start;
      int  accepted;
      int  idx;
      bit  taken;
      nrst           = 1'b1;
      i_instr_valid  = 1'b0;
      i_instr        = '0;
      i_commit_ready = 1'b1;
      rand_ready     = 1'b0;
      rng_ready      = 32'h3202;
      rng_gap        = 32'h3202;
      errors         = 0;
      checks         = 0;
      tests_run      = 0;
      tests_failed   = 0;
      timed_out      = 1'b0;
      $readmemh("sim/alu_patterns.txt", pat);
      repeat (16) @(posedge clk);
      nrst <= 1'b0;

      err_start = errors;
      @(posedge clk);
      checks++;
      if (o_commit_valid !== 1'b0 || o_instr_ready !== 1'b1) begin
         errors++;
         $display("Error at %0t: after reset commit_valid=%b instr_ready=%b", $time,
                  o_commit_valid, o_instr_ready);
      end
      report_test(1, "reset state", err_start);

      err_start = errors;
      run_lines(0, 7, 1'b0);
      drain();
      report_test(2, "r-format ops", err_start);

      err_start = errors;
      run_lines(8, 14, 1'b0);
      drain();
      report_test(3, "i-format ops and r0", err_start);

      // same chain twice, second pass with random gaps and commit stalls
      err_start = errors;
      run_lines(15, 22, 1'b0);
      drain();
      rand_ready <= 1'b1;
      run_lines(15, 22, 1'b1);
      drain();
      rand_ready <= 1'b0;
      @(posedge clk);
      i_commit_ready <= 1'b1;
      report_test(4, "dependency chains", err_start);

      err_start = errors;
      if (!timed_out) begin
         i_commit_ready <= 1'b0;
         accepted = 0;
         idx      = 23;
         taken    = 1'b1;
         while (taken && idx <= 32) begin
            send_line(idx, FILL_LIMIT, taken);
            if (taken) begin
               accepted++;
               idx++;
            end
         end
         checks++;
         if (accepted != ROB_DEPTH) begin
            errors++;
            $display("Error at %0t: %0d accepted with commits blocked, expected %0d",
                     $time, accepted, ROB_DEPTH);
         end
         i_commit_ready <= 1'b1; // release the head
         run_lines(idx, 32, 1'b0);
         drain();
      end
      report_test(5, "commit back-pressure", err_start);

      $display("tests run %0d, failed %0d, checks %0d, errors %0d", tests_run,
               tests_failed, checks, errors);
      if (errors == 0 && tests_failed == 0 && !timed_out) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// File: sim.f
rtl/fcpu_pkg.sv
rtl/reorder_buffer.sv
rtl/dispatch_unit.sv
rtl/alu_station.sv
rtl/reg_file.sv
rtl/fcpu_backend.sv
sim/tb_fcpu_backend.sv

// File: sim/alu_patterns.txt
// columns: instruction word, expected destination register, expected committed value
// all hex, values follow program order from zeroed registers
// r-format block, seeded by two addi
20201234 01 00001234
20400F0F 02 00000F0F
04611000 03 00002143
08811000 04 00000325
0CA11000 05 00000204
10C11000 06 00001F3F
14E11000 07 00001D3B
09020800 08 FFFFFCDB
// i-format block, negative immediates and a write to r0
2121FFFF 09 00001233
2140FF00 0A FFFFFF00
25628001 0B FFFF8F0E
258AFFFF 0C 000000FF
20010005 00 00001239
05A06000 0D 000000FF
21C07FFF 0E 00007FFF
// dependency chain, starts from r0 so it can run twice
21E00011 0F 00000011
060F7800 10 00000022
0A307800 11 00000011
15F18000 0F 00000033
224FFFFE 12 00000031
0E727800 13 00000031
12938800 14 00000031
0AA0A000 15 FFFFFFCF
// back-pressure block, ten lines
22C00100 16 00000100
22F60023 17 00000123
0717B000 18 00000223
2738FFF0 19 FFFFFDD3
0B56C000 1A FFFFFEDD
0F79D000 1B FFFFFCD1
1397D800 1C FFFFFDF3
07BDB000 1D 00000100
23C08000 1E FFFF8000
17FEE000 1F 00007DF3
